/* source/rx_buffer_pkg.sv */
// ----------------------------------------
// Shared sizes and enums for the receive
// buffer. Referenced by scoped name from
// every module and from the testbench
// ----------------------------------------
package rx_buffer_pkg;

  // Buffer geometry
  localparam int BUF_ADDR_W     = 10;
  localparam int WORD_W         = 64;
  localparam int BYTE_ADDR_W    = BUF_ADDR_W + 3;
  localparam int BYTES_PER_WORD = 8;

  // Read size on the access port
  // Byte count is one shifted left by the size
  typedef enum logic [1:0] {
    SIZE_8  = 2'd0,
    SIZE_16 = 2'd1,
    SIZE_32 = 2'd2,
    SIZE_64 = 2'd3
  } access_size_e;

  // Arbiter ownership of the RAM
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_LOADER,
    ARB_READER
  } arb_state_e;

  typedef enum logic [1:0] {
    LOAD_IDLE,
    LOAD_COPY,
    LOAD_DONE
  } load_state_e;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_WAIT_GRANT,
    RD_FIRST,
    RD_SECOND,
    RD_ASSEMBLE
  } read_state_e;

endpackage

/* source/ram_port_if.sv */
// ----------------------------------------
// One client's request path into the
// buffer memory. Clients hold req high as
// long as they need the RAM
// ----------------------------------------
`timescale 1ns/1ps

interface ram_port_if;

  logic                              req;
  logic                              grant;
  logic [rx_buffer_pkg::BUF_ADDR_W-1:0] addr;
  logic                              wr_en;
  logic [rx_buffer_pkg::WORD_W-1:0]  wr_data;
  logic [rx_buffer_pkg::WORD_W-1:0]  rd_data;

  modport client (
    output req, addr, wr_en, wr_data,
    input  grant, rd_data
  );

  modport memory (
    input  req, addr, wr_en, wr_data,
    output grant, rd_data
  );

endinterface

/* source/packet_loader.sv */
// ----------------------------------------
// Copies one packet from the dispatch FIFO
// into the buffer from word 0 upwards and
// pulses packet-read when the FIFO drains
// ----------------------------------------
`timescale 1ns/1ps

module packet_loader (
  input  logic                             i_clk,
  input  logic                             i_areset,
  input  logic                             i_parser_busy,
  input  logic                             i_dispatch_packet_available,
  input  logic                             i_dispatch_fifo_empty,
  input  logic [rx_buffer_pkg::WORD_W-1:0] i_dispatch_fifo_rd_data,
  output logic                             o_dispatch_fifo_rd_en,
  output logic                             o_dispatch_packet_read,
  ram_port_if.client                       ram
);

  rx_buffer_pkg::load_state_e           state;
  logic [rx_buffer_pkg::BUF_ADDR_W-1:0] wr_addr;
  logic                                 packet_read;
  logic                                 start_ok;
  logic                                 copy_word;

  // A packet can only start when the parser is free
  assign start_ok = i_dispatch_packet_available && !i_dispatch_fifo_empty &&
                    !i_parser_busy;

  // Head word moves whenever we own the RAM and the FIFO has data
  assign copy_word = (state == rx_buffer_pkg::LOAD_COPY) && ram.grant &&
                     !i_dispatch_fifo_empty;

  // ----------------------------------------
  // RAM client side
  // ----------------------------------------
  assign ram.req     = (state == rx_buffer_pkg::LOAD_COPY);
  assign ram.addr    = wr_addr;
  assign ram.wr_en   = copy_word;
  assign ram.wr_data = i_dispatch_fifo_rd_data;

  // The FIFO is FWFT so the pop lands in the same cycle as the write
  assign o_dispatch_fifo_rd_en  = copy_word;
  assign o_dispatch_packet_read = packet_read;

  // ----------------------------------------
  // Load FSM
  // ----------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state       <= rx_buffer_pkg::LOAD_IDLE;
      wr_addr     <= '0;
      packet_read <= 1'b0;
    end else begin
      packet_read <= 1'b0;
      case (state)
        rx_buffer_pkg::LOAD_IDLE: begin
          wr_addr <= '0;
          if (start_ok) begin
            state <= rx_buffer_pkg::LOAD_COPY;
          end
        end
        rx_buffer_pkg::LOAD_COPY: begin
          if (copy_word) begin
            wr_addr <= wr_addr + 1'b1;
          end else if (ram.grant) begin
            // FIFO ran dry while granted so the packet is complete
            state       <= rx_buffer_pkg::LOAD_DONE;
            packet_read <= 1'b1;
          end
        end
        rx_buffer_pkg::LOAD_DONE: begin
          // Wait for the dispatcher to retire the packet
          if (!i_dispatch_packet_available) begin
            state <= rx_buffer_pkg::LOAD_IDLE;
          end
        end
        default: state <= rx_buffer_pkg::LOAD_IDLE;
      endcase
    end
  end

endmodule

/* source/access_reader.sv */
// ----------------------------------------
// Access port reads of 8 to 64 bits at any
// byte address. Fetches one or two words
// and returns the bytes right-aligned
// ----------------------------------------
`timescale 1ns/1ps

module access_reader (
  input  logic                                  i_clk,
  input  logic                                  i_areset,
  input  logic                                  i_access_port_rd_en,
  input  logic [rx_buffer_pkg::BYTE_ADDR_W-1:0] i_access_port_addr,
  input  rx_buffer_pkg::access_size_e           i_access_port_wordsize,
  output logic                                  o_access_port_wait,
  output logic                                  o_access_port_rd_dv,
  output logic [rx_buffer_pkg::WORD_W-1:0]      o_access_port_rd_data,
  ram_port_if.client                            ram
);

  localparam int W = rx_buffer_pkg::WORD_W;

  rx_buffer_pkg::read_state_e           state;
  logic                                 wait_q;
  logic                                 dv_q;
  logic [W-1:0]                         rd_data_q;

  // Latched request
  logic [rx_buffer_pkg::BUF_ADDR_W-1:0] word_addr_q;
  logic [rx_buffer_pkg::BUF_ADDR_W-1:0] next_addr;
  logic [2:0]                           offset_q;
  rx_buffer_pkg::access_size_e          size_q;

  // Fetched words with the first one as the more significant half
  logic [W-1:0]                         word_hi_q;
  logic [W-1:0]                         word_lo_q;

  logic [3:0]                           byte_count;
  logic [4:0]                           byte_end;
  logic                                 span;
  logic [6:0]                           shift_r;
  logic [2*W-1:0]                       window;
  logic [2*W-1:0]                       shifted_win;
  logic [W-1:0]                         result;

  // ----------------------------------------
  // Span and byte extraction
  // ----------------------------------------
  assign byte_count = 4'd1 << size_q;
  assign byte_end   = {2'b00, offset_q} + {1'b0, byte_count};
  assign span       = byte_end > 5'(rx_buffer_pkg::BYTES_PER_WORD);

  // Top of the buffer wraps back to word 0
  assign next_addr  = word_addr_q + 1'b1;

  // Big-endian window shifted so the offset byte ends up at the top
  assign window      = {word_hi_q, word_lo_q};
  assign shifted_win = window << {offset_q, 3'b000};
  assign shift_r     = 7'(W) - {byte_count, 3'b000};
  assign result      = shifted_win[2*W-1:W] >> shift_r;

  // ----------------------------------------
  // RAM client side for reads only
  // ----------------------------------------
  assign ram.req     = (state == rx_buffer_pkg::RD_WAIT_GRANT) ||
                       (state == rx_buffer_pkg::RD_FIRST && span);
  assign ram.addr    = (state == rx_buffer_pkg::RD_FIRST) ? next_addr : word_addr_q;
  assign ram.wr_en   = 1'b0;
  assign ram.wr_data = '0;

  assign o_access_port_wait    = wait_q;
  assign o_access_port_rd_dv   = dv_q;
  assign o_access_port_rd_data = rd_data_q;

  // ----------------------------------------
  // Read FSM
  // ----------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state     <= rx_buffer_pkg::RD_IDLE;
      wait_q    <= 1'b0;
      dv_q      <= 1'b0;
      rd_data_q <= '0;
    end else begin
      dv_q <= 1'b0;
      case (state)
        rx_buffer_pkg::RD_IDLE: begin
          if (i_access_port_rd_en) begin
            wait_q <= 1'b1;
            state  <= rx_buffer_pkg::RD_WAIT_GRANT;
          end
        end
        rx_buffer_pkg::RD_WAIT_GRANT: begin
          // First word address goes out on the granted cycle
          if (ram.grant) begin
            state <= rx_buffer_pkg::RD_FIRST;
          end
        end
        rx_buffer_pkg::RD_FIRST: begin
          state <= span ? rx_buffer_pkg::RD_SECOND : rx_buffer_pkg::RD_ASSEMBLE;
        end
        rx_buffer_pkg::RD_SECOND: state <= rx_buffer_pkg::RD_ASSEMBLE;
        rx_buffer_pkg::RD_ASSEMBLE: begin
          rd_data_q <= result;
          dv_q      <= 1'b1;
          wait_q    <= 1'b0;
          state     <= rx_buffer_pkg::RD_IDLE;
        end
        default: state <= rx_buffer_pkg::RD_IDLE;
      endcase
    end
  end

  // Request and word capture
  always_ff @(posedge i_clk) begin
    if (state == rx_buffer_pkg::RD_IDLE && i_access_port_rd_en) begin
      word_addr_q <= i_access_port_addr[rx_buffer_pkg::BYTE_ADDR_W-1:3];
      offset_q    <= i_access_port_addr[2:0];
      size_q      <= i_access_port_wordsize;
    end
    if (state == rx_buffer_pkg::RD_FIRST) begin
      word_hi_q <= ram.rd_data;
    end
    if (state == rx_buffer_pkg::RD_SECOND) begin
      word_lo_q <= ram.rd_data;
    end
  end

endmodule

/* source/buffer_memory.sv */
// ----------------------------------------
// Buffer RAM shared by loader and reader.
// One client owns the RAM at a time and
// the loader wins a tie from idle
// ----------------------------------------
`timescale 1ns/1ps

module buffer_memory (
  input  logic        i_clk,
  input  logic        i_areset,
  ram_port_if.memory  loader,
  ram_port_if.memory  reader
);

  localparam int DEPTH = 2 ** rx_buffer_pkg::BUF_ADDR_W;

  rx_buffer_pkg::arb_state_e            state;
  logic [rx_buffer_pkg::WORD_W-1:0]     mem [DEPTH];
  logic [rx_buffer_pkg::WORD_W-1:0]     rd_data_q;
  logic [rx_buffer_pkg::BUF_ADDR_W-1:0] ram_addr;
  logic [rx_buffer_pkg::WORD_W-1:0]     ram_wr_data;
  logic                                 ram_wr_en;
  logic                                 loader_sel;
  logic                                 reader_sel;

  // ----------------------------------------
  // Arbiter
  // ----------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state <= rx_buffer_pkg::ARB_IDLE;
    end else begin
      case (state)
        rx_buffer_pkg::ARB_IDLE: begin
          if (loader.req) begin
            state <= rx_buffer_pkg::ARB_LOADER;
          end else if (reader.req) begin
            state <= rx_buffer_pkg::ARB_READER;
          end
        end
        rx_buffer_pkg::ARB_LOADER: begin
          if (!loader.req) state <= rx_buffer_pkg::ARB_IDLE;
        end
        rx_buffer_pkg::ARB_READER: begin
          if (!reader.req) state <= rx_buffer_pkg::ARB_IDLE;
        end
        default: state <= rx_buffer_pkg::ARB_IDLE;
      endcase
    end
  end

  // Grants come straight from the state register
  assign loader_sel   = (state == rx_buffer_pkg::ARB_LOADER);
  assign reader_sel   = (state == rx_buffer_pkg::ARB_READER);
  assign loader.grant = loader_sel;
  assign reader.grant = reader_sel;

  // Steer the owner onto the RAM
  assign ram_addr    = loader_sel ? loader.addr : reader.addr;
  assign ram_wr_data = loader_sel ? loader.wr_data : reader.wr_data;
  assign ram_wr_en   = (loader_sel && loader.wr_en) || (reader_sel && reader.wr_en);

  // ----------------------------------------
  // Synchronous single port RAM
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (ram_wr_en) begin
      mem[ram_addr] <= ram_wr_data;
    end
    rd_data_q <= mem[ram_addr];
  end

  assign loader.rd_data = rd_data_q;
  assign reader.rd_data = rd_data_q;

endmodule

/* source/rx_buffer.sv */
// ----------------------------------------
// Receive buffer top level. Loader and
// reader share the buffer memory through
// two RAM request ports
// ----------------------------------------
`timescale 1ns/1ps

module rx_buffer (
  input  logic                                  i_clk,
  input  logic                                  i_areset,
  input  logic                                  i_parser_busy,
  input  logic                                  i_dispatch_packet_available,
  input  logic                                  i_dispatch_fifo_empty,
  input  logic [rx_buffer_pkg::WORD_W-1:0]      i_dispatch_fifo_rd_data,
  output logic                                  o_dispatch_fifo_rd_en,
  output logic                                  o_dispatch_packet_read,
  input  logic                                  i_access_port_rd_en,
  input  logic [rx_buffer_pkg::BYTE_ADDR_W-1:0] i_access_port_addr,
  input  rx_buffer_pkg::access_size_e           i_access_port_wordsize,
  output logic                                  o_access_port_wait,
  output logic                                  o_access_port_rd_dv,
  output logic [rx_buffer_pkg::WORD_W-1:0]      o_access_port_rd_data
);

  ram_port_if load_port ();
  ram_port_if read_port ();

  packet_loader u_packet_loader (
    .i_clk                       (i_clk),
    .i_areset                    (i_areset),
    .i_parser_busy               (i_parser_busy),
    .i_dispatch_packet_available (i_dispatch_packet_available),
    .i_dispatch_fifo_empty       (i_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_data     (i_dispatch_fifo_rd_data),
    .o_dispatch_fifo_rd_en       (o_dispatch_fifo_rd_en),
    .o_dispatch_packet_read      (o_dispatch_packet_read),
    .ram                         (load_port.client)
  );

  access_reader u_access_reader (
    .i_clk                  (i_clk),
    .i_areset               (i_areset),
    .i_access_port_rd_en    (i_access_port_rd_en),
    .i_access_port_addr     (i_access_port_addr),
    .i_access_port_wordsize (i_access_port_wordsize),
    .o_access_port_wait     (o_access_port_wait),
    .o_access_port_rd_dv    (o_access_port_rd_dv),
    .o_access_port_rd_data  (o_access_port_rd_data),
    .ram                    (read_port.client)
  );

  buffer_memory u_buffer_memory (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .loader   (load_port.memory),
    .reader   (read_port.memory)
  );

endmodule

/* dv/tb_clock.sv */
// ----------------------------------------
// Testbench clock and active high reset.
// The reset is released on a falling edge
// after the given number of cycles
// ----------------------------------------
`timescale 1ns/1ps

module tb_clock #(
  parameter int CLK_PERIOD   = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_areset
);

  initial begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_areset = 1'b1;
    #(CLK_PERIOD * RESET_CYCLES);
    o_areset = 1'b0;
  end

endmodule

/* dv/rx_buffer_tb.sv */
// ----------------------------------------
// Testbench for the receive buffer. Feeds
// packets through a FWFT FIFO model and
// checks access port reads against a shadow
// copy of the loaded words
// ----------------------------------------
`timescale 1ns/1ps

module rx_buffer_tb;

  localparam int CLK_PERIOD      = 20;
  localparam int PKT1_LEN        = 1024;
  localparam int PKT2_LEN        = 256;
  localparam int NUM_DIRECTED    = 38;
  localparam int NUM_RANDOM      = 200;
  localparam int PKT2_AT_READ    = 50;
  localparam int SEED            = 90406;
  localparam int WATCHDOG_CYCLES =
    (PKT1_LEN + PKT2_LEN + NUM_DIRECTED + NUM_RANDOM) * 20 + 1000;
  localparam logic [9:0] ALIGN_WORDS [4] = '{10'd0, 10'd1, 10'd511, 10'd1023};
  localparam logic [9:0] SPAN_WORDS [2]  = '{10'd3, 10'd1023};

  logic                                  i_clk;
  logic                                  i_areset;
  logic                                  i_parser_busy;
  logic                                  i_dispatch_packet_available = 1'b0;
  logic                                  i_dispatch_fifo_empty = 1'b1;
  logic [rx_buffer_pkg::WORD_W-1:0]      i_dispatch_fifo_rd_data = '0;
  logic                                  o_dispatch_fifo_rd_en;
  logic                                  o_dispatch_packet_read;
  logic                                  i_access_port_rd_en;
  logic [rx_buffer_pkg::BYTE_ADDR_W-1:0] i_access_port_addr;
  rx_buffer_pkg::access_size_e           i_access_port_wordsize;
  logic                                  o_access_port_wait;
  logic                                  o_access_port_rd_dv;
  logic [rx_buffer_pkg::WORD_W-1:0]      o_access_port_rd_data;

  // FIFO model storage written by the stimulus and popped by the DUT
  logic [63:0] fifo_mem [2048];
  int          fifo_wr = 0;
  int          fifo_rd = 0;
  logic [63:0] shadow [1024];
  int          pkt_base = 0;
  int          pkt_len = 0;
  int          launch_count = 0;
  int          done_count = 0;
  logic        pkt_read_prev = 1'b0;

  // Expected read results in issue order
  logic [63:0] exp_data [256];
  logic [12:0] exp_addr [256];
  int          issued = 0;
  int          checked = 0;
  logic [31:0] lcg_state = SEED;

  tb_clock #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) u_clock (
    .o_clk    (i_clk),
    .o_areset (i_areset)
  );

  rx_buffer i_rx_buffer (
    .i_clk                       (i_clk),
    .i_areset                    (i_areset),
    .i_parser_busy               (i_parser_busy),
    .i_dispatch_packet_available (i_dispatch_packet_available),
    .i_dispatch_fifo_empty       (i_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_data     (i_dispatch_fifo_rd_data),
    .o_dispatch_fifo_rd_en       (o_dispatch_fifo_rd_en),
    .o_dispatch_packet_read      (o_dispatch_packet_read),
    .i_access_port_rd_en         (i_access_port_rd_en),
    .i_access_port_addr          (i_access_port_addr),
    .i_access_port_wordsize      (i_access_port_wordsize),
    .o_access_port_wait          (o_access_port_wait),
    .o_access_port_rd_dv         (o_access_port_rd_dv),
    .o_access_port_rd_data       (o_access_port_rd_data)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s, got 0x%h, expected 0x%h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Big-endian bytes from consecutive addresses with the first byte on top and zero fill
  function automatic logic [63:0] expected_read(input logic [12:0] byte_addr,
                                               input logic [1:0] size);
    logic [63:0] value;
    logic [12:0] a;
    int          i;
    int          lo;
    value = '0;
    for (i = 0; i < (1 << size); i++) begin
      a     = byte_addr + 13'(i);
      lo    = 8 * (7 - int'(a[2:0]));
      value = {value[55:0], shadow[a[12:3]][lo +: 8]};
    end
    return value;
  endfunction

  task automatic start_packet(input int len);
    int i;
    @(posedge i_clk);
    pkt_base = fifo_wr;
    pkt_len  = len;
    for (i = 0; i < len; i++) begin
      fifo_mem[fifo_wr] = {next_random(), next_random()};
      fifo_wr++;
    end
    launch_count++;
  endtask

  task automatic issue_read(input logic [12:0] byte_addr, input logic [1:0] size);
    @(negedge i_clk);
    while (o_access_port_wait) @(negedge i_clk);
    exp_addr[issued]       = byte_addr;
    exp_data[issued]       = expected_read(byte_addr, size);
    issued++;
    i_access_port_rd_en    = 1'b1;
    i_access_port_addr     = byte_addr;
    i_access_port_wordsize = rx_buffer_pkg::access_size_e'(size);
    @(negedge i_clk);
    i_access_port_rd_en    = 1'b0;
  endtask

  task automatic wait_reads_idle();
    while (checked != issued || o_access_port_wait) @(negedge i_clk);
  endtask

  // ----------------------------------------
  // Dispatch FIFO model and packet monitor
  // ----------------------------------------
  always @(negedge i_clk) begin
    i_dispatch_packet_available = (launch_count != done_count);
    i_dispatch_fifo_empty       = (fifo_rd == fifo_wr);
    i_dispatch_fifo_rd_data     = (fifo_rd == fifo_wr) ? '0 : fifo_mem[fifo_rd];
  end

  always @(posedge i_clk) begin
    if (!i_areset) begin
      check_value(64'(o_dispatch_packet_read && pkt_read_prev), 64'd0,
                  "packet_read high for more than one cycle");
      if (o_dispatch_fifo_rd_en && fifo_rd == fifo_wr) begin
        stop_run("The loader popped the dispatch FIFO while it was empty");
      end else if (o_dispatch_packet_read && launch_count == done_count) begin
        stop_run("Packet read pulse with no packet pending");
      end else begin
        if (o_dispatch_fifo_rd_en) fifo_rd++;
        if (o_dispatch_packet_read && !pkt_read_prev) begin
          check_value(64'(fifo_wr - fifo_rd), 64'd0, "FIFO words left at packet_read");
          for (int i = 0; i < pkt_len; i++) shadow[i] = fifo_mem[pkt_base + i];
          done_count++;
        end
        pkt_read_prev = o_dispatch_packet_read;
      end
    end
  end

  // Compare each result with the value queued at issue
  always @(posedge i_clk) begin
    if (!i_areset && o_access_port_rd_dv) begin
      if (checked == issued) begin
        stop_run("Read data valid with no read outstanding");
      end else begin
        check_value(64'(o_access_port_wait), 64'd0, "wait still high with rd_dv");
        check_value(o_access_port_rd_data, exp_data[checked],
                    $sformatf("read data at byte 0x%h", exp_addr[checked]));
        checked++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_run("Watchdog timeout, the test did not finish in time");
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] size_rnd;
    logic [12:0] addr;
    logic [9:0]  word;
    int          n;
    int          w;
    int          s;
    int          off;
    i_parser_busy          = 1'b1;
    i_access_port_rd_en    = 1'b0;
    i_access_port_addr     = '0;
    i_access_port_wordsize = rx_buffer_pkg::SIZE_8;
    @(negedge i_areset);
    @(posedge i_clk);
    check_value(64'(o_access_port_wait), 64'd0, "wait after reset");
    check_value(64'(o_access_port_rd_dv), 64'd0, "rd_dv after reset");
    check_value(64'(o_dispatch_fifo_rd_en), 64'd0, "fifo_rd_en after reset");
    check_value(64'(o_dispatch_packet_read), 64'd0, "packet_read after reset");

    // Parser busy holds the load off
    start_packet(PKT1_LEN);
    repeat (10) begin
      @(posedge i_clk);
      check_value(64'(o_dispatch_fifo_rd_en), 64'd0, "fifo_rd_en while parser busy");
    end
    @(negedge i_clk);
    i_parser_busy = 1'b0;
    while (done_count < 1) @(negedge i_clk);

    for (w = 0; w < 4; w++) begin
      for (s = 0; s < 4; s++) issue_read({ALIGN_WORDS[w], 3'd0}, 2'(s));
    end
    // Reads across a word boundary including the wrap to word 0
    for (w = 0; w < 2; w++) begin
      issue_read({SPAN_WORDS[w], 3'd7}, 2'd1);
      for (off = 5; off < 8; off++) issue_read({SPAN_WORDS[w], 3'(off)}, 2'd2);
      for (off = 1; off < 8; off++) issue_read({SPAN_WORDS[w], 3'(off)}, 2'd3);
    end

    for (n = 0; n < NUM_RANDOM; n++) begin
      if (n == PKT2_AT_READ) begin
        wait_reads_idle();
        start_packet(PKT2_LEN);
      end
      rnd      = next_random();
      size_rnd = next_random();
      if (launch_count != done_count) begin
        // Keep clear of the words the second packet rewrites while it is in flight
        word = 10'(PKT2_LEN + int'(rnd[31:16]) % (1023 - PKT2_LEN));
        addr = {word, rnd[10:8]};
      end else begin
        addr = rnd[28:16];
      end
      issue_read(addr, size_rnd[30:29]);
    end

    wait_reads_idle();
    check_value(64'(done_count), 64'd2, "packet_read pulses after the second packet");
    $display("TEST OK");
    $finish;
  end

endmodule

/* sim.f */
source/rx_buffer_pkg.sv
source/ram_port_if.sv
source/packet_loader.sv
source/access_reader.sv
source/buffer_memory.sv
source/rx_buffer.sv
dv/tb_clock.sv
dv/rx_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the receive buffer testbench with Verilator and runs it.
# The exit status is the simulator's, non-zero when the test fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module rx_buffer_tb -Mdir obj_dir -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vrx_buffer_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished with status 0"
exit 0
